// ==== common/axi_macros.svh ====
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// byte address and data bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH   4

`define MEM_DEPTH      256  // ram size in words

`endif

// ==== common/axi_pkg.sv ====
`include "axi_macros.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [7:0]                 len;  // single beat, always zero
    } ar_chan_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [`AXI_ID_WIDTH-1:0]   id;
        resp_e                      resp;
        logic                       last;
    } r_chan_t;

    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [7:0]                 len;
    } aw_chan_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]   data;
        logic [`AXI_DATA_WIDTH/8-1:0] strb;
        logic                         last;
    } w_chan_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        resp_e                    resp;
    } b_chan_t;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    // master index, also carried in bit 0 of the read id
    typedef enum logic {
        MST_IF = 1'b0,
        MST_LS = 1'b1
    } master_e;

endpackage

// ==== hw/axi_chan_reg.sv ====
module axi_chan_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,

    input  payload_t in_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,

    output payload_t out_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    payload_t data_q;
    logic     full_q;
    logic     in_fire;

    // accept when empty or draining this cycle
    assign in_ready_o  = !full_q || out_ready_i;
    assign in_fire     = in_valid_i && in_ready_o;
    assign out_o       = data_q;
    assign out_valid_o = full_q;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            full_q <= 1'b0;
        else if (in_fire)
            full_q <= 1'b1;
        else if (out_ready_i)
            full_q <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (in_fire)
            data_q <= in_i;
    end

    // producer keeps a refused item in place
    a_in_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (in_valid_i && !in_ready_o) |=> (in_valid_i && $stable(in_i)));

endmodule

// ==== hw/axi_crossbar/axi_crossbar.sv ====
module axi_crossbar (
    input  logic               clk_i,
    input  logic               rst_i,

    // instruction fetch master, read only
    input  axi_pkg::ar_chan_t  if_ar_i,
    input  logic               if_ar_valid_i,
    output logic               if_ar_ready_o,
    output axi_pkg::r_chan_t   if_r_o,
    output logic               if_r_valid_o,
    input  logic               if_r_ready_i,

    // load/store master
    input  axi_pkg::ar_chan_t  ls_ar_i,
    input  logic               ls_ar_valid_i,
    output logic               ls_ar_ready_o,
    output axi_pkg::r_chan_t   ls_r_o,
    output logic               ls_r_valid_o,
    input  logic               ls_r_ready_i,
    input  axi_pkg::aw_chan_t  ls_aw_i,
    input  logic               ls_aw_valid_i,
    output logic               ls_aw_ready_o,
    input  axi_pkg::w_chan_t   ls_w_i,
    input  logic               ls_w_valid_i,
    output logic               ls_w_ready_o,
    output axi_pkg::b_chan_t   ls_b_o,
    output logic               ls_b_valid_o,
    input  logic               ls_b_ready_i,

    // shared slave port
    output axi_pkg::ar_chan_t  m_ar_o,
    output logic               m_ar_valid_o,
    input  logic               m_ar_ready_i,
    input  axi_pkg::r_chan_t   m_r_i,
    input  logic               m_r_valid_i,
    output logic               m_r_ready_o,
    output axi_pkg::aw_chan_t  m_aw_o,
    output logic               m_aw_valid_o,
    input  logic               m_aw_ready_i,
    output axi_pkg::w_chan_t   m_w_o,
    output logic               m_w_valid_o,
    input  logic               m_w_ready_i,
    input  axi_pkg::b_chan_t   m_b_i,
    input  logic               m_b_valid_i,
    output logic               m_b_ready_o
);

    core_pkg::master_e rr_ptr_q;     // preferred master on a tie
    core_pkg::master_e lock_sel_q;
    logic              lock_q;       // grant held until handshake
    core_pkg::master_e ar_sel;
    core_pkg::master_e r_dst;
    logic              ar_fire;

    always_comb begin
        if (lock_q)
            ar_sel = lock_sel_q;
        else if (if_ar_valid_i && ls_ar_valid_i)
            ar_sel = rr_ptr_q;
        else if (ls_ar_valid_i)
            ar_sel = core_pkg::MST_LS;
        else
            ar_sel = core_pkg::MST_IF;
    end

    always_comb begin
        if (ar_sel == core_pkg::MST_LS) begin
            m_ar_o       = ls_ar_i;
            m_ar_valid_o = ls_ar_valid_i;
        end else begin
            m_ar_o       = if_ar_i;
            m_ar_valid_o = if_ar_valid_i;
        end
        m_ar_o.id[0] = ar_sel;  // tag with master index
    end

    assign if_ar_ready_o = m_ar_ready_i && (ar_sel == core_pkg::MST_IF);
    assign ls_ar_ready_o = m_ar_ready_i && (ar_sel == core_pkg::MST_LS);
    assign ar_fire       = m_ar_valid_o && m_ar_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rr_ptr_q   <= core_pkg::MST_IF;
            lock_sel_q <= core_pkg::MST_IF;
            lock_q     <= 1'b0;
        end else if (ar_fire) begin
            rr_ptr_q <= (ar_sel == core_pkg::MST_IF) ? core_pkg::MST_LS : core_pkg::MST_IF;
            lock_q   <= 1'b0;
        end else if (m_ar_valid_o) begin
            lock_q     <= 1'b1;
            lock_sel_q <= ar_sel;
        end
    end

    // read data steered back by the id tag
    assign r_dst        = core_pkg::master_e'(m_r_i.id[0]);
    assign if_r_o       = m_r_i;
    assign ls_r_o       = m_r_i;
    assign if_r_valid_o = m_r_valid_i && (r_dst == core_pkg::MST_IF);
    assign ls_r_valid_o = m_r_valid_i && (r_dst == core_pkg::MST_LS);
    assign m_r_ready_o  = (r_dst == core_pkg::MST_LS) ? ls_r_ready_i : if_r_ready_i;

    // writes only come from load/store
    assign m_aw_o        = ls_aw_i;
    assign m_aw_valid_o  = ls_aw_valid_i;
    assign ls_aw_ready_o = m_aw_ready_i;
    assign m_w_o         = ls_w_i;
    assign m_w_valid_o   = ls_w_valid_i;
    assign ls_w_ready_o  = m_w_ready_i;
    assign ls_b_o        = m_b_i;
    assign ls_b_valid_o  = m_b_valid_i;
    assign m_b_ready_o   = ls_b_ready_i;

    // a stalled request keeps its grant and payload
    a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_o)));

endmodule

// ==== hw/axi_ram.sv ====
`include "axi_macros.svh"

module axi_ram (
    input  logic              clk_i,
    input  logic              rst_i,

    input  axi_pkg::ar_chan_t ar_i,
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    output axi_pkg::r_chan_t  r_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,

    input  axi_pkg::aw_chan_t aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  axi_pkg::w_chan_t  w_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output axi_pkg::b_chan_t  b_o,
    output logic              b_valid_o,
    input  logic              b_ready_i
);

    localparam int IDX_W  = $clog2(`MEM_DEPTH);
    localparam int WORD_W = `AXI_ADDR_WIDTH - 2;
    localparam int NBYTES = `AXI_DATA_WIDTH / 8;

    logic [`AXI_DATA_WIDTH-1:0] mem_q [`MEM_DEPTH];

    axi_pkg::r_chan_t  r_q;
    axi_pkg::b_chan_t  b_q;
    logic              r_valid_q;
    logic              b_valid_q;
    logic [WORD_W-1:0] ar_word;
    logic [WORD_W-1:0] aw_word;
    logic              ar_hit;
    logic              aw_hit;
    logic              ar_fire;
    logic              wr_fire;
    logic              b_free;

    assign ar_word = ar_i.addr[`AXI_ADDR_WIDTH-1:2];
    assign aw_word = aw_i.addr[`AXI_ADDR_WIDTH-1:2];
    assign ar_hit  = ar_word < WORD_W'(`MEM_DEPTH);
    assign aw_hit  = aw_word < WORD_W'(`MEM_DEPTH);

    assign ar_ready_o = !r_valid_q || r_ready_i;
    assign ar_fire    = ar_valid_i && ar_ready_o;
    assign b_free     = !b_valid_q || b_ready_i;
    assign aw_ready_o = w_valid_i && b_free;   // aw and w taken together
    assign w_ready_o  = aw_valid_i && b_free;
    assign wr_fire    = aw_valid_i && w_valid_i && b_free;

    assign r_o       = r_q;
    assign r_valid_o = r_valid_q;
    assign b_o       = b_q;
    assign b_valid_o = b_valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_fire)
                r_valid_q <= 1'b1;
            else if (r_ready_i)
                r_valid_q <= 1'b0;
            if (wr_fire)
                b_valid_q <= 1'b1;
            else if (b_ready_i)
                b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            r_q.data <= ar_hit ? mem_q[ar_word[IDX_W-1:0]] : '0;
            r_q.id   <= ar_i.id;
            r_q.resp <= ar_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            r_q.last <= 1'b1;
        end
        if (wr_fire) begin
            b_q.id   <= aw_i.id;
            b_q.resp <= aw_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            for (int i = 0; i < NBYTES; i++) begin
                if (aw_hit && w_i.strb[i])
                    mem_q[aw_word[IDX_W-1:0]][8*i +: 8] <= w_i.data[8*i +: 8];
            end
        end
    end

    a_ar_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ar_fire |-> (ar_i.len == 8'd0));
    a_aw_single: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_fire |-> (aw_i.len == 8'd0));

endmodule

// ==== hw/mem_subsys_top.sv ====
module mem_subsys_top (
    input  logic               clk_i,
    input  logic               rst_i,

    input  axi_pkg::ar_chan_t  if_ar_i,
    input  logic               if_ar_valid_i,
    output logic               if_ar_ready_o,
    output axi_pkg::r_chan_t   if_r_o,
    output logic               if_r_valid_o,
    input  logic               if_r_ready_i,

    input  axi_pkg::ar_chan_t  ls_ar_i,
    input  logic               ls_ar_valid_i,
    output logic               ls_ar_ready_o,
    output axi_pkg::r_chan_t   ls_r_o,
    output logic               ls_r_valid_o,
    input  logic               ls_r_ready_i,
    input  axi_pkg::aw_chan_t  ls_aw_i,
    input  logic               ls_aw_valid_i,
    output logic               ls_aw_ready_o,
    input  axi_pkg::w_chan_t   ls_w_i,
    input  logic               ls_w_valid_i,
    output logic               ls_w_ready_o,
    output axi_pkg::b_chan_t   ls_b_o,
    output logic               ls_b_valid_o,
    input  logic               ls_b_ready_i
);

    axi_pkg::ar_chan_t xbar_ar, ram_ar;
    axi_pkg::r_chan_t  xbar_r, ram_r;
    axi_pkg::aw_chan_t ram_aw;
    axi_pkg::w_chan_t  ram_w;
    axi_pkg::b_chan_t  ram_b;
    logic xbar_ar_valid, xbar_ar_ready, ram_ar_valid, ram_ar_ready;
    logic xbar_r_valid, xbar_r_ready, ram_r_valid, ram_r_ready;
    logic ram_aw_valid, ram_aw_ready, ram_w_valid, ram_w_ready;
    logic ram_b_valid, ram_b_ready;

    axi_crossbar u_xbar (
        .clk_i, .rst_i,
        .if_ar_i, .if_ar_valid_i, .if_ar_ready_o,
        .if_r_o, .if_r_valid_o, .if_r_ready_i,
        .ls_ar_i, .ls_ar_valid_i, .ls_ar_ready_o,
        .ls_r_o, .ls_r_valid_o, .ls_r_ready_i,
        .ls_aw_i, .ls_aw_valid_i, .ls_aw_ready_o,
        .ls_w_i, .ls_w_valid_i, .ls_w_ready_o,
        .ls_b_o, .ls_b_valid_o, .ls_b_ready_i,
        .m_ar_o(xbar_ar), .m_ar_valid_o(xbar_ar_valid), .m_ar_ready_i(xbar_ar_ready),
        .m_r_i(xbar_r), .m_r_valid_i(xbar_r_valid), .m_r_ready_o(xbar_r_ready),
        .m_aw_o(ram_aw), .m_aw_valid_o(ram_aw_valid), .m_aw_ready_i(ram_aw_ready),
        .m_w_o(ram_w), .m_w_valid_o(ram_w_valid), .m_w_ready_i(ram_w_ready),
        .m_b_i(ram_b), .m_b_valid_i(ram_b_valid), .m_b_ready_o(ram_b_ready)
    );

    axi_chan_reg #(.payload_t(axi_pkg::ar_chan_t)) ar_slice (
        .clk_i, .rst_i,
        .in_i(xbar_ar), .in_valid_i(xbar_ar_valid), .in_ready_o(xbar_ar_ready),
        .out_o(ram_ar), .out_valid_o(ram_ar_valid), .out_ready_i(ram_ar_ready)
    );

    axi_chan_reg #(.payload_t(axi_pkg::r_chan_t)) r_slice (
        .clk_i, .rst_i,
        .in_i(ram_r), .in_valid_i(ram_r_valid), .in_ready_o(ram_r_ready),
        .out_o(xbar_r), .out_valid_o(xbar_r_valid), .out_ready_i(xbar_r_ready)
    );

    axi_ram u_ram (
        .clk_i, .rst_i,
        .ar_i(ram_ar), .ar_valid_i(ram_ar_valid), .ar_ready_o(ram_ar_ready),
        .r_o(ram_r), .r_valid_o(ram_r_valid), .r_ready_i(ram_r_ready),
        .aw_i(ram_aw), .aw_valid_i(ram_aw_valid), .aw_ready_o(ram_aw_ready),
        .w_i(ram_w), .w_valid_i(ram_w_valid), .w_ready_o(ram_w_ready),
        .b_o(ram_b), .b_valid_o(ram_b_valid), .b_ready_i(ram_b_ready)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // released after two rising edges
    end

    always #5 clk_o = ~clk_o;

endmodule

// ==== test/tb_mem_subsys.sv ====
`include "axi_macros.svh"

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LINES = 64;

    logic clk, rst;
    axi_pkg::ar_chan_t if_ar, ls_ar;
    axi_pkg::r_chan_t  if_r, ls_r;
    axi_pkg::aw_chan_t ls_aw;
    axi_pkg::w_chan_t  ls_w;
    axi_pkg::b_chan_t  ls_b;
    logic if_ar_valid, if_ar_ready, if_r_valid, if_r_ready;
    logic ls_ar_valid, ls_ar_ready, ls_r_valid, ls_r_ready;
    logic ls_aw_valid, ls_aw_ready, ls_w_valid, ls_w_ready, ls_b_valid, ls_b_ready;

    int                         n_lines;
    int                         line_group [MAX_LINES];
    logic [8*16-1:0]            line_name  [MAX_LINES];
    logic                       line_write [MAX_LINES];
    core_pkg::master_e          line_mst   [MAX_LINES];
    logic [`AXI_ADDR_WIDTH-1:0] line_addr  [MAX_LINES];
    logic [`AXI_DATA_WIDTH-1:0] line_data  [MAX_LINES];
    logic [3:0]                 line_strb  [MAX_LINES];
    axi_pkg::resp_e             line_resp  [MAX_LINES];
    axi_pkg::r_chan_t           exp_r      [MAX_LINES];
    axi_pkg::b_chan_t           exp_b      [MAX_LINES];

    logic [`AXI_DATA_WIDTH-1:0] model_mem [`MEM_DEPTH];  // shadow of the ram
    int     if_issue_q[$], ls_issue_q[$];
    int     if_r_exp_q[$], ls_r_exp_q[$], ls_b_exp_q[$];  // line indices, oldest first
    int     cycles;
    int     timeout_cycles;
    integer seed;

    tb_clk_gen clk_gen (.clk_o(clk), .rst_o(rst));

    mem_subsys_top uut (
        .clk_i(clk), .rst_i(rst),
        .if_ar_i(if_ar), .if_ar_valid_i(if_ar_valid), .if_ar_ready_o(if_ar_ready),
        .if_r_o(if_r), .if_r_valid_o(if_r_valid), .if_r_ready_i(if_r_ready),
        .ls_ar_i(ls_ar), .ls_ar_valid_i(ls_ar_valid), .ls_ar_ready_o(ls_ar_ready),
        .ls_r_o(ls_r), .ls_r_valid_o(ls_r_valid), .ls_r_ready_i(ls_r_ready),
        .ls_aw_i(ls_aw), .ls_aw_valid_i(ls_aw_valid), .ls_aw_ready_o(ls_aw_ready),
        .ls_w_i(ls_w), .ls_w_valid_i(ls_w_valid), .ls_w_ready_o(ls_w_ready),
        .ls_b_o(ls_b), .ls_b_valid_o(ls_b_valid), .ls_b_ready_i(ls_b_ready)
    );

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_r(input logic [8*16-1:0] name, input axi_pkg::r_chan_t exp,
                           input axi_pkg::r_chan_t act);
        // bit 0 of the id carries the master tag
        if (act.data !== exp.data || act.id[`AXI_ID_WIDTH-1:1] !== exp.id[`AXI_ID_WIDTH-1:1]
                || act.resp !== exp.resp || act.last !== exp.last) begin
            $display("FAIL %0s: expected data/id/resp/last %h/%h/%b/%b, actual %h/%h/%b/%b",
                     name, exp.data, exp.id[`AXI_ID_WIDTH-1:1], exp.resp, exp.last,
                     act.data, act.id[`AXI_ID_WIDTH-1:1], act.resp, act.last);
            stop_with_failure();
        end
    endtask

    task automatic check_b(input logic [8*16-1:0] name, input axi_pkg::b_chan_t exp,
                           input axi_pkg::b_chan_t act);
        if (act.id[`AXI_ID_WIDTH-1:1] !== exp.id[`AXI_ID_WIDTH-1:1] || act.resp !== exp.resp) begin
            $display("FAIL %0s: expected id %h resp %b, actual id %h resp %b", name,
                     exp.id[`AXI_ID_WIDTH-1:1], exp.resp, act.id[`AXI_ID_WIDTH-1:1], act.resp);
            stop_with_failure();
        end
    endtask

    task automatic load_stimulus();
        int              fd;
        int              grp;
        logic [8*128-1:0] text;
        logic [8*16-1:0] name, op, mst, resp;
        logic [31:0]     addr, data;
        logic [3:0]      strb;
        fd = $fopen("test/mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/mem_stimulus.txt");
            stop_with_failure();
        end
        n_lines = 0;
        while ($fgets(text, fd) != 0) begin
            // comment lines fail the first field and are skipped
            if ($sscanf(text, "%d %s %s %s %h %h %h %s", grp, name, op, mst, addr, data,
                        strb, resp) == 8 && n_lines < MAX_LINES) begin
                line_group[n_lines] = grp;
                line_name[n_lines]  = name;
                line_write[n_lines] = (op == "write");
                line_mst[n_lines]   = (mst == "ls") ? core_pkg::MST_LS : core_pkg::MST_IF;
                line_addr[n_lines]  = addr;
                line_data[n_lines]  = data;
                line_strb[n_lines]  = strb;
                line_resp[n_lines]  = (resp == "slverr") ? axi_pkg::RESP_SLVERR
                                                         : axi_pkg::RESP_OKAY;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    // expected response from the shadow memory, then queue the request
    task automatic launch_line(input int i);
        logic [`AXI_ADDR_WIDTH-3:0] word;
        logic                       in_range;
        word     = line_addr[i][`AXI_ADDR_WIDTH-1:2];
        in_range = word < `MEM_DEPTH;
        if (line_write[i]) begin
            if (in_range) begin
                for (int b = 0; b < 4; b++) begin
                    if (line_strb[i][b])
                        model_mem[word][8*b +: 8] = line_data[i][8*b +: 8];
                end
            end
            exp_b[i] = '{id: 4'(i), resp: line_resp[i]};
            ls_b_exp_q.push_back(i);
            ls_issue_q.push_back(i);
        end else begin
            exp_r[i] = '{data: '0, id: 4'(i), resp: line_resp[i], last: 1'b1};
            if (in_range)
                exp_r[i].data = model_mem[word];
            if (line_mst[i] == core_pkg::MST_LS) begin
                ls_r_exp_q.push_back(i);
                ls_issue_q.push_back(i);
            end else begin
                if_r_exp_q.push_back(i);
                if_issue_q.push_back(i);
            end
        end
    endtask

    function automatic logic busy();
        return if_issue_q.size() + ls_issue_q.size() + if_r_exp_q.size()
               + ls_r_exp_q.size() + ls_b_exp_q.size() != 0;
    endfunction

    // drive on the falling edge, sample what the next rising edge will take
    task automatic step();
        int i;
        @(negedge clk);
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("timeout after %0d cycles with responses still missing", timeout_cycles);
            stop_with_failure();
        end
        if_r_ready  = ($random(seed) & 3) != 0;
        ls_r_ready  = ($random(seed) & 3) != 0;
        ls_b_ready  = ($random(seed) & 3) != 0;
        if_ar_valid = if_issue_q.size() != 0;
        if (if_ar_valid)
            if_ar = '{addr: line_addr[if_issue_q[0]], id: 4'(if_issue_q[0]), len: 8'd0};
        ls_ar_valid = 1'b0;
        ls_aw_valid = 1'b0;
        ls_w_valid  = 1'b0;
        if (ls_issue_q.size() != 0) begin
            i = ls_issue_q[0];
            if (line_write[i]) begin
                ls_aw       = '{addr: line_addr[i], id: 4'(i), len: 8'd0};
                ls_w        = '{data: line_data[i], strb: line_strb[i], last: 1'b1};
                ls_aw_valid = 1'b1;
                ls_w_valid  = 1'b1;
            end else begin
                ls_ar       = '{addr: line_addr[i], id: 4'(i), len: 8'd0};
                ls_ar_valid = 1'b1;
            end
        end
        #1;
        if (if_ar_valid && if_ar_ready)
            void'(if_issue_q.pop_front());
        if ((ls_ar_valid && ls_ar_ready) || (ls_aw_valid && ls_aw_ready && ls_w_ready))
            void'(ls_issue_q.pop_front());
        if (if_r_valid && if_r_ready) begin
            if (if_r_exp_q.size() == 0) begin
                $display("read response on the fetch port that no request asked for");
                stop_with_failure();
            end
            i = if_r_exp_q.pop_front();
            check_r(line_name[i], exp_r[i], if_r);
        end
        if (ls_r_valid && ls_r_ready) begin
            if (ls_r_exp_q.size() == 0) begin
                $display("read response on the load/store port that no request asked for");
                stop_with_failure();
            end
            i = ls_r_exp_q.pop_front();
            check_r(line_name[i], exp_r[i], ls_r);
        end
        if (ls_b_valid && ls_b_ready) begin
            if (ls_b_exp_q.size() == 0) begin
                $display("write response that no request asked for");
                stop_with_failure();
            end
            i = ls_b_exp_q.pop_front();
            check_b(line_name[i], exp_b[i], ls_b);
        end
    endtask

    // no response may show up while nothing is outstanding
    task automatic check_idle(input logic [8*16-1:0] name, input int n_cycles);
        repeat (n_cycles) begin
            step();
            if (if_r_valid || ls_r_valid || ls_b_valid) begin
                $display("FAIL %0s: expected valids 000, actual %b%b%b", name,
                         if_r_valid, ls_r_valid, ls_b_valid);
                stop_with_failure();
            end
        end
    endtask

    initial begin
        int idx;
        int grp;
        seed        = 32'h14b0fed2;
        cycles      = 0;
        if_ar       = '0;
        ls_ar       = '0;
        ls_aw       = '0;
        ls_w        = '0;
        if_ar_valid = 1'b0;
        ls_ar_valid = 1'b0;
        ls_aw_valid = 1'b0;
        ls_w_valid  = 1'b0;
        if_r_ready  = 1'b0;
        ls_r_ready  = 1'b0;
        ls_b_ready  = 1'b0;
        for (int k = 0; k < `MEM_DEPTH; k++)
            model_mem[k] = '0;
        load_stimulus();
        timeout_cycles = 50 * n_lines + 100;
        wait (rst === 1'b1);
        wait (rst === 1'b0);

        check_idle("reset_state", 4);

        // a group goes out together and drains before the next one
        idx = 0;
        while (idx < n_lines) begin
            grp = line_group[idx];
            while (idx < n_lines && line_group[idx] == grp) begin
                launch_line(idx);
                idx++;
            end
            while (busy())
                step();
        end

        // a duplicated last response would show up here
        check_idle("after_drain", 4);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== test/mem_stimulus.txt ====
# group name op master addr data strb resp (addr data strb in hex)
# master is if or ls, resp is okay or slverr, data and strb unused on reads
0 wr_full0  write ls 00000000 11223344 f okay
0 wr_full1  write ls 00000004 a5a5a5a5 f okay
0 wr_full2  write ls 00000010 deadbeef f okay
0 wr_full3  write ls 000003fc 01020304 f okay
1 wr_part0  write ls 00000000 aabbccdd 5 okay
1 wr_part1  write ls 00000004 00ff0000 c okay
1 rd_ls0    read  ls 00000000 00000000 0 okay
1 rd_ls1    read  ls 00000004 00000000 0 okay
2 rd_if0    read  if 00000010 00000000 0 okay
2 rd_if1    read  if 000003fc 00000000 0 okay
3 ovl_if0   read  if 00000000 00000000 0 okay
3 ovl_ls0   read  ls 00000010 00000000 0 okay
3 ovl_if1   read  if 00000004 00000000 0 okay
3 ovl_ls1   read  ls 000003fc 00000000 0 okay
4 oor_wr    write ls 00000400 ffffffff f slverr
4 oor_rd_ls read  ls 00001000 00000000 0 slverr
4 oor_rd_if read  if 00000800 00000000 0 slverr
5 keep_ls   read  ls 00000000 00000000 0 okay
5 keep_if   read  if 00000004 00000000 0 okay

// ==== verilog.f ====
+incdir+common
common/axi_pkg.sv
common/core_pkg.sv
hw/axi_chan_reg.sv
hw/axi_crossbar/axi_crossbar.sv
hw/axi_ram.sv
hw/mem_subsys_top.sv
test/tb_clk_gen.sv
test/tb_mem_subsys.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' verilog.f) common/axi_macros.svh

obj_dir/Vtb_mem_subsys: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f verilog.f

run: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
